/* rtl/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)

// sram window, depth in words
`define SRAM_BASE 32'h0000_0000
`define SRAM_WORDS 256

// gpio window: offset 0 gpio_out, offset 4 gpio_in
`define GPIO_BASE 32'h1000_0000
`define GPIO_SPAN 8
`define GPIO_W 8

`endif

/* rtl/soc_pkg.sv */
`include "soc_cfg.svh"

package soc_pkg;

    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0] axi_resp_t;
    typedef logic [`GPIO_W-1:0] gpio_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // arbiter grant
    typedef enum logic [1:0] {IDLE, GRANT_FETCH, GRANT_LSU} arb_state_e;

    // crossbar target of the transaction in flight
    typedef enum logic [1:0] {SEL_NONE, SEL_SRAM, SEL_GPIO, SEL_ERR} slv_sel_e;

    // slave handshake fsm
    typedef enum logic [1:0] {SLV_IDLE, SLV_RDATA, SLV_BRESP} slv_state_e;

endpackage

/* rtl/axi_lite_if.sv */
`timescale 1ns/1ns

interface axi_lite_if import soc_pkg::*; ();

    axi_addr_t araddr;
    logic arvalid;
    logic arready;

    axi_data_t rdata;
    axi_resp_t rresp;
    logic rvalid;
    logic rready;

    axi_addr_t awaddr;
    logic awvalid;
    logic awready;

    axi_data_t wdata;
    axi_strb_t wstrb;
    logic wvalid;
    logic wready;

    axi_resp_t bresp;
    logic bvalid;
    logic bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

/* rtl/axi_arbiter.sv */
`timescale 1ns/1ns

module axi_arbiter import soc_pkg::*; (
    input logic clk,
    input logic rst_n,

    // fetch unit, read only
    input axi_addr_t fetch_araddr,
    input logic fetch_arvalid,
    output logic fetch_arready,
    output axi_data_t fetch_rdata,
    output axi_resp_t fetch_rresp,
    output logic fetch_rvalid,
    input logic fetch_rready,

    // load-store unit
    input axi_addr_t lsu_araddr,
    input logic lsu_arvalid,
    output logic lsu_arready,
    output axi_data_t lsu_rdata,
    output axi_resp_t lsu_rresp,
    output logic lsu_rvalid,
    input logic lsu_rready,
    input axi_addr_t lsu_awaddr,
    input logic lsu_awvalid,
    output logic lsu_awready,
    input axi_data_t lsu_wdata,
    input axi_strb_t lsu_wstrb,
    input logic lsu_wvalid,
    output logic lsu_wready,
    output axi_resp_t lsu_bresp,
    output logic lsu_bvalid,
    input logic lsu_bready,

    axi_lite_if.master xbar
);

    arb_state_e state;
    arb_state_e state_next;
    logic fetch_gnt;
    logic lsu_gnt;
    logic r_done;
    logic b_done;

    assign fetch_gnt = (state == GRANT_FETCH);
    assign lsu_gnt = (state == GRANT_LSU);
    assign r_done = xbar.rvalid && xbar.rready;
    assign b_done = xbar.bvalid && xbar.bready;

    // lsu wins over fetch, grant held until the response is taken
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (lsu_arvalid || lsu_awvalid) begin
                    state_next = GRANT_LSU;
                end else if (fetch_arvalid) begin
                    state_next = GRANT_FETCH;
                end
            end
            GRANT_FETCH: begin
                if (r_done) begin
                    state_next = IDLE;
                end
            end
            GRANT_LSU: begin
                if (r_done || b_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request side toward the crossbar
    always_comb begin
        xbar.araddr = '0;
        xbar.arvalid = 1'b0;
        xbar.rready = 1'b0;
        xbar.awaddr = '0;
        xbar.awvalid = 1'b0;
        xbar.wdata = '0;
        xbar.wstrb = '0;
        xbar.wvalid = 1'b0;
        xbar.bready = 1'b0;
        if (lsu_gnt) begin
            xbar.araddr = lsu_araddr;
            xbar.arvalid = lsu_arvalid;
            xbar.rready = lsu_rready;
            xbar.awaddr = lsu_awaddr;
            xbar.awvalid = lsu_awvalid;
            xbar.wdata = lsu_wdata;
            xbar.wstrb = lsu_wstrb;
            xbar.wvalid = lsu_wvalid;
            xbar.bready = lsu_bready;
        end else if (fetch_gnt) begin
            xbar.araddr = fetch_araddr;
            xbar.arvalid = fetch_arvalid;
            xbar.rready = fetch_rready;
        end
    end

    // losers see zeros
    assign fetch_arready = fetch_gnt && xbar.arready;
    assign fetch_rdata = fetch_gnt ? xbar.rdata : '0;
    assign fetch_rresp = fetch_gnt ? xbar.rresp : RESP_OKAY;
    assign fetch_rvalid = fetch_gnt && xbar.rvalid;

    assign lsu_arready = lsu_gnt && xbar.arready;
    assign lsu_rdata = lsu_gnt ? xbar.rdata : '0;
    assign lsu_rresp = lsu_gnt ? xbar.rresp : RESP_OKAY;
    assign lsu_rvalid = lsu_gnt && xbar.rvalid;
    assign lsu_awready = lsu_gnt && xbar.awready;
    assign lsu_wready = lsu_gnt && xbar.wready;
    assign lsu_bresp = lsu_gnt ? xbar.bresp : RESP_OKAY;
    assign lsu_bvalid = lsu_gnt && xbar.bvalid;

    // an unaccepted response keeps the lsu grant
    a_lsu_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_gnt && ((xbar.rvalid && !xbar.rready) || (xbar.bvalid && !xbar.bready))
        |=> state == GRANT_LSU);

endmodule

/* rtl/axi_xbar.sv */
`timescale 1ns/1ns
`include "soc_cfg.svh"

module axi_xbar import soc_pkg::*; (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave up,
    axi_lite_if.master sram,
    axi_lite_if.master gpio
);

    localparam axi_addr_t SRAM_LO = `SRAM_BASE;
    localparam axi_addr_t SRAM_HI = `SRAM_BASE + `SRAM_WORDS * `AXI_STRB_W;
    localparam axi_addr_t GPIO_LO = `GPIO_BASE;
    localparam axi_addr_t GPIO_HI = `GPIO_BASE + `GPIO_SPAN;

    slv_sel_e sel;
    slv_sel_e rd_dec;
    slv_sel_e wr_dec;
    logic is_wr;
    logic rd_req;
    logic wr_req;
    logic sram_req;
    logic gpio_req;

    function automatic slv_sel_e decode(input axi_addr_t addr);
        if (addr >= SRAM_LO && addr < SRAM_HI) begin
            return SEL_SRAM;
        end else if (addr >= GPIO_LO && addr < GPIO_HI) begin
            return SEL_GPIO;
        end
        return SEL_ERR;
    endfunction

    assign rd_dec = decode(up.araddr);
    assign wr_dec = decode(up.awaddr);

    // one transaction at a time, read first
    assign rd_req = (sel == SEL_NONE) && up.arvalid;
    assign wr_req = (sel == SEL_NONE) && !up.arvalid && up.awvalid;

    // payloads go to both slaves, only the valids are steered
    assign sram.araddr = up.araddr;
    assign sram.awaddr = up.awaddr;
    assign sram.wdata = up.wdata;
    assign sram.wstrb = up.wstrb;
    assign gpio.araddr = up.araddr;
    assign gpio.awaddr = up.awaddr;
    assign gpio.wdata = up.wdata;
    assign gpio.wstrb = up.wstrb;

    assign sram.arvalid = rd_req && (rd_dec == SEL_SRAM);
    assign sram.awvalid = wr_req && (wr_dec == SEL_SRAM);
    assign sram.wvalid = wr_req && (wr_dec == SEL_SRAM) && up.wvalid;
    assign gpio.arvalid = rd_req && (rd_dec == SEL_GPIO);
    assign gpio.awvalid = wr_req && (wr_dec == SEL_GPIO);
    assign gpio.wvalid = wr_req && (wr_dec == SEL_GPIO) && up.wvalid;

    always_comb begin
        up.arready = 1'b0;
        up.awready = 1'b0;
        up.wready = 1'b0;
        if (rd_req) begin
            case (rd_dec)
                SEL_SRAM: up.arready = sram.arready;
                SEL_GPIO: up.arready = gpio.arready;
                default: up.arready = 1'b1;
            endcase
        end else if (wr_req) begin
            case (wr_dec)
                SEL_SRAM: begin
                    up.awready = sram.awready;
                    up.wready = sram.wready;
                end
                SEL_GPIO: begin
                    up.awready = gpio.awready;
                    up.wready = gpio.wready;
                end
                default: begin
                    // unmapped: take aw and w together
                    up.awready = up.wvalid;
                    up.wready = 1'b1;
                end
            endcase
        end
    end

    // response from the slave that took the address
    always_comb begin
        up.rvalid = 1'b0;
        up.rdata = '0;
        up.rresp = RESP_OKAY;
        up.bvalid = 1'b0;
        up.bresp = RESP_OKAY;
        case (sel)
            SEL_SRAM: begin
                up.rvalid = sram.rvalid;
                up.rdata = sram.rdata;
                up.rresp = sram.rresp;
                up.bvalid = sram.bvalid;
                up.bresp = sram.bresp;
            end
            SEL_GPIO: begin
                up.rvalid = gpio.rvalid;
                up.rdata = gpio.rdata;
                up.rresp = gpio.rresp;
                up.bvalid = gpio.bvalid;
                up.bresp = gpio.bresp;
            end
            SEL_ERR: begin
                up.rvalid = !is_wr;
                up.rresp = RESP_DECERR;
                up.bvalid = is_wr;
                up.bresp = RESP_DECERR;
            end
            default: ;
        endcase
    end

    assign sram.rready = (sel == SEL_SRAM) && up.rready;
    assign sram.bready = (sel == SEL_SRAM) && up.bready;
    assign gpio.rready = (sel == SEL_GPIO) && up.rready;
    assign gpio.bready = (sel == SEL_GPIO) && up.bready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel <= SEL_NONE;
            is_wr <= 1'b0;
        end else if (sel == SEL_NONE) begin
            if (up.arvalid && up.arready) begin
                sel <= rd_dec;
                is_wr <= 1'b0;
            end else if (up.awvalid && up.awready) begin
                sel <= wr_dec;
                is_wr <= 1'b1;
            end
        end else if ((up.rvalid && up.rready) || (up.bvalid && up.bready)) begin
            sel <= SEL_NONE;
        end
    end

    assign sram_req = sram.arvalid || sram.awvalid;
    assign gpio_req = gpio.arvalid || gpio.awvalid;

    // requests reach one slave, and only while nothing is in flight
    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        (sram_req || gpio_req) |-> (sel == SEL_NONE) && !(sram_req && gpio_req));

endmodule

/* rtl/axi_sram.sv */
`timescale 1ns/1ns
`include "soc_cfg.svh"

module axi_sram import soc_pkg::*; (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave bus
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    axi_data_t mem [`SRAM_WORDS];
    axi_data_t rdata_q;
    slv_state_e state;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic wr_go;

    // word index, wraps at the depth
    assign rd_idx = bus.araddr[IDX_W+1:2];
    assign wr_idx = bus.awaddr[IDX_W+1:2];

    assign wr_go = (state == SLV_IDLE) && !bus.arvalid && bus.awvalid && bus.wvalid;

    assign bus.arready = (state == SLV_IDLE);
    assign bus.awready = wr_go;
    assign bus.wready = wr_go;
    assign bus.rvalid = (state == SLV_RDATA);
    assign bus.rdata = rdata_q;
    assign bus.rresp = RESP_OKAY;
    assign bus.bvalid = (state == SLV_BRESP);
    assign bus.bresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SLV_IDLE;
        end else begin
            case (state)
                SLV_IDLE: begin
                    if (bus.arvalid) begin
                        state <= SLV_RDATA;
                    end else if (wr_go) begin
                        state <= SLV_BRESP;
                    end
                end
                SLV_RDATA: if (bus.rready) state <= SLV_IDLE;
                SLV_BRESP: if (bus.bready) state <= SLV_IDLE;
                default: state <= SLV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready) begin
            rdata_q <= mem[rd_idx];
        end
        if (wr_go) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (bus.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    a_rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));

endmodule

/* rtl/axi_gpio.sv */
`timescale 1ns/1ns
`include "soc_cfg.svh"

module axi_gpio import soc_pkg::*; (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave bus,
    input gpio_t gpio_in,
    output gpio_t gpio_out
);

    slv_state_e state;
    axi_data_t rdata_q;
    gpio_t in_meta;
    gpio_t in_sync;
    logic wr_go;

    assign wr_go = (state == SLV_IDLE) && !bus.arvalid && bus.awvalid && bus.wvalid;

    assign bus.arready = (state == SLV_IDLE);
    assign bus.awready = wr_go;
    assign bus.wready = wr_go;
    assign bus.rvalid = (state == SLV_RDATA);
    assign bus.rdata = rdata_q;
    assign bus.rresp = RESP_OKAY;
    assign bus.bvalid = (state == SLV_BRESP);
    assign bus.bresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SLV_IDLE;
            gpio_out <= '0;
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            // two-flop synchronizer on the pins
            in_meta <= gpio_in;
            in_sync <= in_meta;
            case (state)
                SLV_IDLE: begin
                    if (bus.arvalid) begin
                        state <= SLV_RDATA;
                    end else if (wr_go) begin
                        state <= SLV_BRESP;
                    end
                end
                SLV_RDATA: if (bus.rready) state <= SLV_IDLE;
                SLV_BRESP: if (bus.bready) state <= SLV_IDLE;
                default: state <= SLV_IDLE;
            endcase
            // offset 4 is read only
            if (wr_go && !bus.awaddr[2] && bus.wstrb[0]) begin
                gpio_out <= bus.wdata[`GPIO_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready) begin
            rdata_q <= bus.araddr[2] ? axi_data_t'(in_sync) : axi_data_t'(gpio_out);
        end
    end

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top import soc_pkg::*; (
    input logic clk,
    input logic rst_n,

    input axi_addr_t fetch_araddr,
    input logic fetch_arvalid,
    output logic fetch_arready,
    output axi_data_t fetch_rdata,
    output axi_resp_t fetch_rresp,
    output logic fetch_rvalid,
    input logic fetch_rready,

    input axi_addr_t lsu_araddr,
    input logic lsu_arvalid,
    output logic lsu_arready,
    output axi_data_t lsu_rdata,
    output axi_resp_t lsu_rresp,
    output logic lsu_rvalid,
    input logic lsu_rready,
    input axi_addr_t lsu_awaddr,
    input logic lsu_awvalid,
    output logic lsu_awready,
    input axi_data_t lsu_wdata,
    input axi_strb_t lsu_wstrb,
    input logic lsu_wvalid,
    output logic lsu_wready,
    output axi_resp_t lsu_bresp,
    output logic lsu_bvalid,
    input logic lsu_bready,

    input gpio_t gpio_in,
    output gpio_t gpio_out
);

    axi_lite_if arb_bus ();
    axi_lite_if sram_bus ();
    axi_lite_if gpio_bus ();

    axi_arbiter u_arbiter (
        .clk (clk),
        .rst_n (rst_n),
        .fetch_araddr (fetch_araddr),
        .fetch_arvalid (fetch_arvalid),
        .fetch_arready (fetch_arready),
        .fetch_rdata (fetch_rdata),
        .fetch_rresp (fetch_rresp),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rready (fetch_rready),
        .lsu_araddr (lsu_araddr),
        .lsu_arvalid (lsu_arvalid),
        .lsu_arready (lsu_arready),
        .lsu_rdata (lsu_rdata),
        .lsu_rresp (lsu_rresp),
        .lsu_rvalid (lsu_rvalid),
        .lsu_rready (lsu_rready),
        .lsu_awaddr (lsu_awaddr),
        .lsu_awvalid (lsu_awvalid),
        .lsu_awready (lsu_awready),
        .lsu_wdata (lsu_wdata),
        .lsu_wstrb (lsu_wstrb),
        .lsu_wvalid (lsu_wvalid),
        .lsu_wready (lsu_wready),
        .lsu_bresp (lsu_bresp),
        .lsu_bvalid (lsu_bvalid),
        .lsu_bready (lsu_bready),
        .xbar (arb_bus.master)
    );

    axi_xbar u_xbar (
        .clk (clk),
        .rst_n (rst_n),
        .up (arb_bus.slave),
        .sram (sram_bus.master),
        .gpio (gpio_bus.master)
    );

    axi_sram u_sram (
        .clk (clk),
        .rst_n (rst_n),
        .bus (sram_bus.slave)
    );

    axi_gpio u_gpio (
        .clk (clk),
        .rst_n (rst_n),
        .bus (gpio_bus.slave),
        .gpio_in (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ns
`include "soc_cfg.svh"

module tb_mem_subsys import soc_pkg::*; ();

    localparam int TIMEOUT = 50;
    localparam axi_addr_t UNMAPPED_RD = 32'h2000_0000;
    localparam axi_addr_t UNMAPPED_WR = 32'h8000_0000;

    logic clk;
    logic rst_n;
    axi_addr_t fetch_araddr;
    logic fetch_arvalid;
    logic fetch_arready;
    axi_data_t fetch_rdata;
    axi_resp_t fetch_rresp;
    logic fetch_rvalid;
    logic fetch_rready;
    axi_addr_t lsu_araddr;
    logic lsu_arvalid;
    logic lsu_arready;
    axi_data_t lsu_rdata;
    axi_resp_t lsu_rresp;
    logic lsu_rvalid;
    logic lsu_rready;
    axi_addr_t lsu_awaddr;
    logic lsu_awvalid;
    logic lsu_awready;
    axi_data_t lsu_wdata;
    axi_strb_t lsu_wstrb;
    logic lsu_wvalid;
    logic lsu_wready;
    axi_resp_t lsu_bresp;
    logic lsu_bvalid;
    logic lsu_bready;
    gpio_t gpio_in;
    gpio_t gpio_out;

    int errors;
    int checks;
    int cycle;
    int lsu_done_cycle;
    int fetch_ar_cycle;
    integer seed;
    axi_data_t ref_mem [`SRAM_WORDS];

    mem_subsys_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_error(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // reference rule for a strobed write
    function automatic axi_data_t apply_strobe(input axi_data_t old_word,
                                               input axi_data_t new_word,
                                               input axi_strb_t strb);
        axi_data_t merged;
        merged = old_word;
        for (int b = 0; b < `AXI_STRB_W; b++) begin
            if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    task automatic lsu_write(input axi_addr_t addr, input axi_data_t data,
                             input axi_strb_t strb, output axi_resp_t resp);
        int n;
        @(posedge clk);
        lsu_awaddr <= addr;
        lsu_awvalid <= 1'b1;
        lsu_wdata <= data;
        lsu_wstrb <= strb;
        lsu_wvalid <= 1'b1;
        lsu_bready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(lsu_awready && lsu_wready) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) report_error("timeout waiting for load-store awready and wready");
        // handshake on this edge
        @(posedge clk);
        lsu_awvalid <= 1'b0;
        lsu_wvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!lsu_bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) report_error("timeout waiting for load-store bvalid");
        resp = lsu_bresp;
        lsu_done_cycle = cycle;
        @(posedge clk);
        lsu_bready <= 1'b0;
    endtask

    // hold > 0 keeps rready low for that many cycles after rvalid
    task automatic lsu_read(input axi_addr_t addr, input int hold,
                            output axi_data_t data, output axi_resp_t resp);
        int n;
        @(posedge clk);
        lsu_araddr <= addr;
        lsu_arvalid <= 1'b1;
        lsu_rready <= (hold == 0);
        n = 0;
        @(negedge clk);
        while (!lsu_arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) report_error("timeout waiting for load-store arready");
        @(posedge clk);
        lsu_arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!lsu_rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) report_error("timeout waiting for load-store rvalid");
        data = lsu_rdata;
        resp = lsu_rresp;
        lsu_done_cycle = cycle;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            lsu_rready <= 1'b1;
        end
        @(posedge clk);
        lsu_rready <= 1'b0;
    endtask

    task automatic fetch_read(input axi_addr_t addr, output axi_data_t data,
                              output axi_resp_t resp);
        int n;
        @(posedge clk);
        fetch_araddr <= addr;
        fetch_arvalid <= 1'b1;
        fetch_rready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!fetch_arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) report_error("timeout waiting for fetch arready");
        fetch_ar_cycle = cycle;
        @(posedge clk);
        fetch_arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!fetch_rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) report_error("timeout waiting for fetch rvalid");
        data = fetch_rdata;
        resp = fetch_rresp;
        @(posedge clk);
        fetch_rready <= 1'b0;
    endtask

    // responses stay put until taken
    a_lsu_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
        else report_error("load-store read response dropped or changed before rready");

    // only one master sees the bus at a time
    a_one_master: assert property (@(posedge clk) disable iff (!rst_n)
        !((fetch_arready || fetch_rvalid) &&
          (lsu_arready || lsu_awready || lsu_wready || lsu_rvalid || lsu_bvalid)))
        else report_error("fetch and load-store unit served in the same cycle");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !(fetch_arready || fetch_rvalid || lsu_arready || lsu_rvalid ||
                           lsu_awready || lsu_wready || lsu_bvalid) && gpio_out == '0)
        else report_error("valid, ready or gpio_out not cleared by reset");

    a_decerr_zero: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid && lsu_rresp == RESP_DECERR |-> lsu_rdata == '0)
        else report_error("decode error read returned nonzero rdata");

    initial begin
        axi_resp_t resp;
        axi_resp_t fresp;
        axi_data_t rd;
        axi_data_t frd;
        axi_data_t data;
        axi_strb_t strb;
        axi_addr_t addr;
        gpio_t pins;
        int idx;
        int hold;

        errors = 0;
        checks = 0;
        cycle = 0;
        lsu_done_cycle = 0;
        fetch_ar_cycle = 0;
        seed = 26056;
        rst_n = 1'b0;
        fetch_araddr = '0;
        fetch_arvalid = 1'b0;
        fetch_rready = 1'b0;
        lsu_araddr = '0;
        lsu_arvalid = 1'b0;
        lsu_rready = 1'b0;
        lsu_awaddr = '0;
        lsu_awvalid = 1'b0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        lsu_wvalid = 1'b0;
        lsu_bready = 1'b0;
        gpio_in = '0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // known contents in every sram word
        for (int i = 0; i < `SRAM_WORDS; i++) begin
            data = $random(seed);
            lsu_write(`SRAM_BASE + i * 4, data, 4'hf, resp);
            ref_mem[i] = data;
            check_value("sram fill bresp", RESP_OKAY, resp);
        end

        // strobed write then read back
        repeat (8) begin
            idx = $unsigned($random(seed)) % `SRAM_WORDS;
            addr = `SRAM_BASE + idx * 4;
            data = $random(seed);
            strb = $random(seed);
            lsu_write(addr, data, strb, resp);
            ref_mem[idx] = apply_strobe(ref_mem[idx], data, strb);
            check_value("strobed write bresp", RESP_OKAY, resp);
            lsu_read(addr, 0, rd, resp);
            check_value("strobed read data", ref_mem[idx], rd);
            check_value("strobed read rresp", RESP_OKAY, resp);
        end

        // fetch sees the last load-store write
        fetch_read(addr, rd, resp);
        check_value("fetch read data", ref_mem[idx], rd);
        check_value("fetch read rresp", RESP_OKAY, resp);

        // both masters on the same edge, lsu goes first
        idx = $unsigned($random(seed)) % `SRAM_WORDS;
        addr = `SRAM_BASE + idx * 4;
        data = $random(seed);
        ref_mem[idx] = data;
        fork
            lsu_write(addr, data, 4'hf, resp);
            fetch_read(addr, frd, fresp);
        join
        checks++;
        assert (fetch_ar_cycle > lsu_done_cycle)
            else report_error("fetch granted before the load-store write completed");
        check_value("race fetch data", data, frd);
        check_value("race fetch rresp", RESP_OKAY, fresp);

        // gpio output register
        data = $random(seed);
        lsu_write(`GPIO_BASE, data, 4'h1, resp);
        check_value("gpio write bresp", RESP_OKAY, resp);
        check_value("gpio_out pins", {24'b0, data[7:0]}, {24'b0, gpio_out});
        lsu_read(`GPIO_BASE, 0, rd, resp);
        check_value("gpio_out readback", {24'b0, data[7:0]}, rd);

        // gpio input through the synchronizer
        pins = $random(seed);
        @(posedge clk);
        gpio_in <= pins;
        repeat (3) @(posedge clk);
        lsu_read(`GPIO_BASE + 4, 0, rd, resp);
        check_value("gpio_in read", {24'b0, pins}, rd);

        // unmapped addresses
        lsu_read(UNMAPPED_RD + idx * 4, 0, rd, resp);
        check_value("unmapped read rresp", RESP_DECERR, resp);
        check_value("unmapped read data", 32'h0, rd);
        lsu_write(UNMAPPED_WR + idx * 4, $random(seed), 4'hf, resp);
        check_value("unmapped write bresp", RESP_DECERR, resp);
        lsu_read(addr, 0, rd, resp);
        check_value("sram after unmapped write", ref_mem[idx], rd);

        // back-pressure on the read response
        repeat (3) begin
            idx = $unsigned($random(seed)) % `SRAM_WORDS;
            hold = 1 + $unsigned($random(seed)) % 6;
            lsu_read(`SRAM_BASE + idx * 4, hold, rd, resp);
            check_value("held read data", ref_mem[idx], rd);
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/axi_lite_if.sv
rtl/axi_arbiter.sv
rtl/axi_xbar.sv
rtl/axi_sram.sv
rtl/axi_gpio.sv
rtl/mem_subsys_top.sv
sim/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_pkg.sv
      - rtl/axi_lite_if.sv
      - rtl/axi_arbiter.sv
      - rtl/axi_xbar.sv
      - rtl/axi_sram.sv
      - rtl/axi_gpio.sv
      - rtl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/tb_mem_subsys.sv
